/* Bender.yml */
package:
  name: mem_wb

sources:
  - include_dirs:
      - include
    files:
      - logic/cpu_pkg.sv
      - logic/lsu.sv
      - logic/wb_select.sv
      - logic/data_sram_axi.sv
      - logic/wb_stage.sv
      - logic/mem_wb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_mem_wb.sv

/* all.f */
+incdir+include
logic/cpu_pkg.sv
logic/lsu.sv
logic/wb_select.sv
logic/data_sram_axi.sv
logic/wb_stage.sv
logic/mem_wb_top.sv
verif/tb_mem_wb.sv

/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data and address width
`define XLEN 32

// Integer register file entries
`define NUM_REGS 32

// CSR file entries, addressed by csr_rd
`define NUM_CSRS 4

// Data memory depth in words
`define MEM_WORDS 1024

// Response delays, counted from the accepted address beat
`define MEM_READ_LAT 2
`define MEM_WRITE_LAT 1

`endif

/* logic/cpu_pkg.sv */
package cpu_pkg;

  // Load/store unit FSM
  typedef enum logic [2:0] {
    IDLE,
    READ_ADDR,
    READ_RESP,
    WRITE_ADDR,
    WRITE_RESP,
    DONE
  } lsu_state_t;

  // Register write value source
  typedef enum logic [1:0] {
    WD_ALU,
    WD_LOAD,
    WD_LINK,
    WD_SRC2
  } wd_sel_t;

  // CSR write value source
  typedef enum logic {
    CSR_WD_ALU,
    CSR_WD_PC
  } csr_wd_sel_t;

  typedef enum logic [1:0] {
    OKAY,
    EXOKAY,
    SLVERR,
    DECERR
  } axi_resp_t;

endpackage

/* logic/data_sram_axi.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module data_sram_axi
  import cpu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [`XLEN-1:0] araddr,
  input  logic             arvalid,
  output logic             arready,
  output logic [`XLEN-1:0] rdata,
  output axi_resp_t        rresp,
  output logic             rvalid,
  input  logic             rready,
  input  logic [`XLEN-1:0] awaddr,
  input  logic             awvalid,
  output logic             awready,
  input  logic [`XLEN-1:0] wdata,
  input  logic [7:0]       wstrb,
  input  logic             wvalid,
  output logic             wready,
  output axi_resp_t        bresp,
  output logic             bvalid,
  input  logic             bready
);

  logic [`XLEN-1:0]               mem [`MEM_WORDS];
  logic [$clog2(`MEM_WORDS)-1:0]  rd_idx;
  logic [1:0]                     rd_off;
  logic                           open_q;  // One transaction at a time
  logic                           rd_q;
  logic                           resp_q;
  logic [7:0]                     lat_cnt;
  logic                           ar_beat;
  logic                           aw_beat;
  logic                           resp_due;

  assign ar_beat  = arvalid && arready;
  assign aw_beat  = awvalid && awready && wvalid && wready;
  assign resp_due = open_q && !resp_q && (lat_cnt == 8'd1);

  assign arready = !open_q;
  assign awready = !open_q;
  assign wready  = !open_q;
  assign rvalid  = resp_q && rd_q;
  assign bvalid  = resp_q && !rd_q;
  assign rresp   = OKAY;
  assign bresp   = OKAY;

  always_ff @(posedge clk) begin
    if (rst) begin
      open_q  <= 1'b0;
      rd_q    <= 1'b0;
      resp_q  <= 1'b0;
      lat_cnt <= '0;
    end else if (ar_beat) begin
      open_q  <= 1'b1;
      rd_q    <= 1'b1;
      lat_cnt <= 8'(`MEM_READ_LAT);
    end else if (aw_beat) begin
      open_q  <= 1'b1;
      rd_q    <= 1'b0;
      lat_cnt <= 8'(`MEM_WRITE_LAT);
    end else if (resp_due) begin
      resp_q <= 1'b1;
    end else if (open_q && !resp_q) begin
      lat_cnt <= lat_cnt - 8'd1;
    end else if ((rvalid && rready) || (bvalid && bready)) begin
      open_q <= 1'b0;
      resp_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_beat) begin
      rd_idx <= araddr[$clog2(`MEM_WORDS)+1:2];
      rd_off <= araddr[1:0];
    end
    if (aw_beat) begin
      for (int b = 0; b < `XLEN/8; b++) begin
        if (wstrb[b]) mem[awaddr[$clog2(`MEM_WORDS)+1:2]][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
    if (resp_due && rd_q) rdata <= mem[rd_idx] >> {rd_off, 3'b000};  // Addressed byte to lane 0
  end

endmodule

/* logic/lsu.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module lsu
  import cpu_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          lsu_receive_valid,
  input  logic                          ren,
  input  logic                          wen,
  input  logic                          mem_signed,
  input  logic [7:0]                    wmask,
  input  logic [`XLEN-1:0]              rmask,
  input  logic [`XLEN-1:0]              exu_result,
  input  logic [`XLEN-1:0]              pc,
  input  logic [`XLEN-1:0]              pc_next,
  input  logic [`XLEN-1:0]              instruction,
  input  logic [`XLEN-1:0]              src2,
  input  logic [`XLEN-1:0]              rsb,
  input  wd_sel_t                       wd_sel,
  input  csr_wd_sel_t                   csr_wd_sel,
  input  logic [$clog2(`NUM_REGS)-1:0]  rd,
  input  logic [$clog2(`NUM_CSRS)-1:0]  csr_rd,
  input  logic                          reg_write_en,
  input  logic                          csreg_write_en,
  input  logic                          ecall,
  input  logic                          arready,
  input  logic [`XLEN-1:0]              rdata,
  input  axi_resp_t                     rresp,
  input  logic                          rvalid,
  input  logic                          awready,
  input  logic                          wready,
  input  axi_resp_t                     bresp,
  input  logic                          bvalid,
  output logic                          lsu_send_valid,
  output logic                          lsu_send_ready,
  output logic                          lsu_state,
  output logic [`XLEN-1:0]              wb_exu_result,
  output logic [`XLEN-1:0]              wb_src2,
  output logic [`XLEN-1:0]              wb_pc,
  output logic [`XLEN-1:0]              wb_pc_next,
  output logic [`XLEN-1:0]              wb_instruction,
  output logic [`XLEN-1:0]              wb_rmask,
  output logic                          wb_mem_signed,
  output wd_sel_t                       wb_wd_sel,
  output csr_wd_sel_t                   wb_csr_wd_sel,
  output logic [$clog2(`NUM_REGS)-1:0]  wb_rd,
  output logic [$clog2(`NUM_CSRS)-1:0]  wb_csr_rd,
  output logic                          wb_reg_write_en,
  output logic                          wb_csreg_write_en,
  output logic                          wb_ecall,
  output logic [`XLEN-1:0]              load_word,
  output logic [`XLEN-1:0]              araddr,
  output logic                          arvalid,
  output logic                          rready,
  output logic [`XLEN-1:0]              awaddr,
  output logic                          awvalid,
  output logic [`XLEN-1:0]              wdata,
  output logic [7:0]                    wstrb,
  output logic                          wvalid,
  output logic                          bready
);

  lsu_state_t state;
  lsu_state_t next_state;
  logic       accept;

  assign accept = (state == IDLE) && lsu_receive_valid;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (lsu_receive_valid) next_state = ren ? READ_ADDR : (wen ? WRITE_ADDR : DONE);
      end
      READ_ADDR: begin
        if (arvalid && arready) next_state = READ_RESP;
      end
      READ_RESP: begin
        if (rvalid && rready && (rresp == OKAY)) next_state = DONE;
      end
      WRITE_ADDR: begin
        if (awvalid && awready && wvalid && wready) next_state = WRITE_RESP;
      end
      WRITE_RESP: begin
        if (bvalid && bready && (bresp == OKAY)) next_state = DONE;
      end
      DONE:    next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= IDLE;
      lsu_send_ready <= 1'b0;
      rready         <= 1'b0;
      bready         <= 1'b0;
    end else begin
      state          <= next_state;
      lsu_send_ready <= accept;  // One cycle, on leaving IDLE
      rready         <= 1'b1;
      bready         <= 1'b1;
    end
  end

  // Instruction fields, held until the next accept
  always_ff @(posedge clk) begin
    if (accept) begin
      wb_exu_result     <= exu_result;
      wb_src2           <= src2;
      wb_pc             <= pc;
      wb_pc_next        <= pc_next;
      wb_instruction    <= instruction;
      wb_rmask          <= rmask;
      wb_mem_signed     <= mem_signed;
      wb_wd_sel         <= wd_sel;
      wb_csr_wd_sel     <= csr_wd_sel;
      wb_rd             <= rd;
      wb_csr_rd         <= csr_rd;
      wb_reg_write_en   <= reg_write_en;
      wb_csreg_write_en <= csreg_write_en;
      wb_ecall          <= ecall;
      wdata             <= rsb;  // Already in its byte lanes
      wstrb             <= wmask;
    end
    if ((state == READ_RESP) && rvalid && rready) load_word <= rdata;
  end

  assign araddr  = wb_exu_result;
  assign awaddr  = wb_exu_result;
  assign arvalid = (state == READ_ADDR);
  assign awvalid = (state == WRITE_ADDR);
  assign wvalid  = (state == WRITE_ADDR);

  assign lsu_send_valid = (state == DONE);
  assign lsu_state      = (next_state != IDLE);  // Busy until back in IDLE

endmodule

/* logic/mem_wb_top.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module mem_wb_top
  import cpu_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          lsu_receive_valid,
  output logic                          lsu_send_ready,
  output logic                          lsu_state,
  input  logic                          ren,
  input  logic                          wen,
  input  logic                          mem_signed,
  input  logic [7:0]                    wmask,
  input  logic [`XLEN-1:0]              rmask,
  input  logic [`XLEN-1:0]              exu_result,
  input  logic [`XLEN-1:0]              pc,
  input  logic [`XLEN-1:0]              pc_next,
  input  logic [`XLEN-1:0]              instruction,
  input  logic [`XLEN-1:0]              src2,
  input  logic [`XLEN-1:0]              rsb,
  input  wd_sel_t                       wd_sel,
  input  csr_wd_sel_t                   csr_wd_sel,
  input  logic [$clog2(`NUM_REGS)-1:0]  rd,
  input  logic [$clog2(`NUM_CSRS)-1:0]  csr_rd,
  input  logic                          reg_write_en,
  input  logic                          csreg_write_en,
  input  logic                          ecall,
  input  logic [$clog2(`NUM_REGS)-1:0]  rs1_addr,
  output logic [`XLEN-1:0]              rs1_data,
  input  logic [$clog2(`NUM_REGS)-1:0]  rs2_addr,
  output logic [`XLEN-1:0]              rs2_data,
  input  logic [$clog2(`NUM_CSRS)-1:0]  csr_raddr,
  output logic [`XLEN-1:0]              csr_rdata,
  output logic                          commit_valid,
  output logic [`XLEN-1:0]              commit_pc,
  output logic [`XLEN-1:0]              commit_pc_next,
  output logic [`XLEN-1:0]              commit_instr,
  output logic [$clog2(`NUM_REGS)-1:0]  commit_rd,
  output logic [`XLEN-1:0]              commit_wd,
  output logic                          commit_ecall
);

  logic                          lsu_send_valid;
  logic [`XLEN-1:0]              wb_exu_result;
  logic [`XLEN-1:0]              wb_src2;
  logic [`XLEN-1:0]              wb_pc;
  logic [`XLEN-1:0]              wb_pc_next;
  logic [`XLEN-1:0]              wb_instruction;
  logic [`XLEN-1:0]              wb_rmask;
  logic                          wb_mem_signed;
  wd_sel_t                       wb_wd_sel;
  csr_wd_sel_t                   wb_csr_wd_sel;
  logic [$clog2(`NUM_REGS)-1:0]  wb_rd;
  logic [$clog2(`NUM_CSRS)-1:0]  wb_csr_rd;
  logic                          wb_reg_write_en;
  logic                          wb_csreg_write_en;
  logic                          wb_ecall;
  logic [`XLEN-1:0]              load_word;
  logic [`XLEN-1:0]              wd;
  logic [`XLEN-1:0]              csr_wd;

  // AXI-lite between LSU and data memory
  logic [`XLEN-1:0]              araddr;
  logic                          arvalid;
  logic                          arready;
  logic [`XLEN-1:0]              rdata;
  axi_resp_t                     rresp;
  logic                          rvalid;
  logic                          rready;
  logic [`XLEN-1:0]              awaddr;
  logic                          awvalid;
  logic                          awready;
  logic [`XLEN-1:0]              wdata;
  logic [7:0]                    wstrb;
  logic                          wvalid;
  logic                          wready;
  axi_resp_t                     bresp;
  logic                          bvalid;
  logic                          bready;

  lsu u_lsu (.*);

  data_sram_axi u_data_sram (.*);

  wb_select u_wb_select (
    .load_word  (load_word),
    .rmask      (wb_rmask),
    .mem_signed (wb_mem_signed),
    .exu_result (wb_exu_result),
    .src2       (wb_src2),
    .pc         (wb_pc),
    .wd_sel     (wb_wd_sel),
    .csr_wd_sel (wb_csr_wd_sel),
    .wd         (wd),
    .csr_wd     (csr_wd)
  );

  wb_stage u_wb_stage (
    .clk            (clk),
    .rst            (rst),
    .lsu_send_valid (lsu_send_valid),
    .rd             (wb_rd),
    .csr_rd         (wb_csr_rd),
    .reg_write_en   (wb_reg_write_en),
    .csreg_write_en (wb_csreg_write_en),
    .wd             (wd),
    .csr_wd         (csr_wd),
    .pc             (wb_pc),
    .pc_next        (wb_pc_next),
    .instruction    (wb_instruction),
    .ecall          (wb_ecall),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .csr_raddr      (csr_raddr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .csr_rdata      (csr_rdata),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_pc_next (commit_pc_next),
    .commit_instr   (commit_instr),
    .commit_rd      (commit_rd),
    .commit_wd      (commit_wd),
    .commit_ecall   (commit_ecall)
  );

endmodule

/* logic/wb_select.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module wb_select
  import cpu_pkg::*;
(
  input  logic [`XLEN-1:0] load_word,
  input  logic [`XLEN-1:0] rmask,
  input  logic             mem_signed,
  input  logic [`XLEN-1:0] exu_result,
  input  logic [`XLEN-1:0] src2,
  input  logic [`XLEN-1:0] pc,
  input  wd_sel_t          wd_sel,
  input  csr_wd_sel_t      csr_wd_sel,
  output logic [`XLEN-1:0] wd,
  output logic [`XLEN-1:0] csr_wd
);

  logic [`XLEN-1:0] load_val;

  // Byte and halfword loads extend from their top bit when signed
  always_comb begin
    case (rmask)
      32'h0000_00ff: load_val = {{(`XLEN-8){mem_signed & load_word[7]}}, load_word[7:0]};
      32'h0000_ffff: load_val = {{(`XLEN-16){mem_signed & load_word[15]}}, load_word[15:0]};
      32'hffff_ffff: load_val = load_word;
      default:       load_val = '0;
    endcase
  end

  always_comb begin
    case (wd_sel)
      WD_ALU:  wd = exu_result;
      WD_LOAD: wd = load_val;
      WD_LINK: wd = pc + 32'd4;  // Return address
      WD_SRC2: wd = src2;
      default: wd = exu_result;
    endcase
  end

  assign csr_wd = (csr_wd_sel == CSR_WD_PC) ? pc : exu_result;

endmodule

/* logic/wb_stage.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module wb_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          lsu_send_valid,
  input  logic [$clog2(`NUM_REGS)-1:0]  rd,
  input  logic [$clog2(`NUM_CSRS)-1:0]  csr_rd,
  input  logic                          reg_write_en,
  input  logic                          csreg_write_en,
  input  logic [`XLEN-1:0]              wd,
  input  logic [`XLEN-1:0]              csr_wd,
  input  logic [`XLEN-1:0]              pc,
  input  logic [`XLEN-1:0]              pc_next,
  input  logic [`XLEN-1:0]              instruction,
  input  logic                          ecall,
  input  logic [$clog2(`NUM_REGS)-1:0]  rs1_addr,
  input  logic [$clog2(`NUM_REGS)-1:0]  rs2_addr,
  input  logic [$clog2(`NUM_CSRS)-1:0]  csr_raddr,
  output logic [`XLEN-1:0]              rs1_data,
  output logic [`XLEN-1:0]              rs2_data,
  output logic [`XLEN-1:0]              csr_rdata,
  output logic                          commit_valid,
  output logic [`XLEN-1:0]              commit_pc,
  output logic [`XLEN-1:0]              commit_pc_next,
  output logic [`XLEN-1:0]              commit_instr,
  output logic [$clog2(`NUM_REGS)-1:0]  commit_rd,
  output logic [`XLEN-1:0]              commit_wd,
  output logic                          commit_ecall
);

  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic [`XLEN-1:0] csrs [`NUM_CSRS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) regs[i] <= '0;
      for (int i = 0; i < `NUM_CSRS; i++) csrs[i] <= '0;
    end else if (lsu_send_valid) begin
      if (reg_write_en && (rd != '0)) regs[rd] <= wd;  // x0 stays zero
      if (csreg_write_en) csrs[csr_rd] <= csr_wd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= lsu_send_valid;
    end
  end

  // Retire record
  always_ff @(posedge clk) begin
    if (lsu_send_valid) begin
      commit_pc      <= pc;
      commit_pc_next <= pc_next;
      commit_instr   <= instruction;
      commit_rd      <= rd;
      commit_wd      <= wd;
      commit_ecall   <= ecall;
    end
  end

  assign rs1_data  = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data  = (rs2_addr == '0) ? '0 : regs[rs2_addr];
  assign csr_rdata = csrs[csr_raddr];

endmodule

/* verif/tb_mem_wb.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_mem_wb
  import cpu_pkg::*;
;

  localparam int RW = $clog2(`NUM_REGS);
  localparam int CW = $clog2(`NUM_CSRS);
  localparam int AW = $clog2(`MEM_WORDS);
  localparam int NUM_OPS = 260;       // Directed, preload and random ops
  localparam int OP_CYCLES = 20;      // Worst case per op with read-back
  localparam int CYCLE_LIMIT = NUM_OPS * OP_CYCLES + 800;

  logic clk, rst, lsu_receive_valid, lsu_send_ready, lsu_state;
  logic ren, wen, mem_signed, reg_write_en, csreg_write_en, ecall;
  logic [7:0] wmask;
  logic [`XLEN-1:0] rmask, exu_result, pc, pc_next, instruction, src2, rsb;
  wd_sel_t wd_sel;
  csr_wd_sel_t csr_wd_sel;
  logic [RW-1:0] rd, rs1_addr, rs2_addr, commit_rd;
  logic [CW-1:0] csr_rd, csr_raddr;
  logic [`XLEN-1:0] rs1_data, rs2_data, csr_rdata;
  logic commit_valid, commit_ecall;
  logic [`XLEN-1:0] commit_pc, commit_pc_next, commit_instr, commit_wd;

  // Reference state
  logic [`XLEN-1:0] ref_mem [`MEM_WORDS];
  logic [`XLEN-1:0] ref_regs [`NUM_REGS];
  logic [`XLEN-1:0] ref_csrs [`NUM_CSRS];
  logic [`XLEN-1:0] issue_pc;

  // Outstanding ops, oldest first
  string name_q[$];
  logic [`XLEN-1:0] exp_wd_q[$];
  logic [`XLEN-1:0] exp_pc_q[$];
  logic [`XLEN-1:0] exp_pc_next_q[$];
  logic [`XLEN-1:0] exp_instr_q[$];
  logic [RW-1:0] exp_rd_q[$];
  logic exp_ecall_q[$];

  int value_errors, protocol_errors, commit_count, cycles;
  int ready_pulses, busy_rises;
  logic busy_q;
  logic fell_q;  // Busy dropped at the previous edge
  string tname;

  mem_wb_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_data(input string name, input logic [`XLEN-1:0] exp,
                            input logic [`XLEN-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_reg_index(input string name, input logic [RW-1:0] exp,
                                 input logic [RW-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      value_errors++;
    end
  endtask

  function automatic logic [`XLEN-1:0] format_load(input logic [`XLEN-1:0] word,
      input logic [`XLEN-1:0] mask, input logic sgn);
    logic [`XLEN-1:0] top_bit;
    logic [`XLEN-1:0] v;
    top_bit = (mask >> 1) + 1;  // Highest bit kept by the mask
    v = word & mask;
    if (mask != 32'h0000_00ff && mask != 32'h0000_ffff && mask != 32'hffff_ffff) v = '0;
    else if (sgn && mask != '1 && (word & top_bit) != 0) v = v | ~mask;
    return v;
  endfunction

  // Expected register write value for one op
  function automatic logic [`XLEN-1:0] predict_wd(input wd_sel_t sel,
      input logic [`XLEN-1:0] alu, input logic [`XLEN-1:0] pc_v,
      input logic [`XLEN-1:0] src2_v, input logic [`XLEN-1:0] mask, input logic sgn);
    logic [`XLEN-1:0] word;
    word = ref_mem[alu[AW+1:2]] >> (8 * alu[1:0]);
    case (sel)
      WD_LOAD: return format_load(word, mask, sgn);
      WD_LINK: return pc_v + 4;
      WD_SRC2: return src2_v;
      default: return alu;
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] predict_csr(input csr_wd_sel_t sel,
      input logic [`XLEN-1:0] alu, input logic [`XLEN-1:0] pc_v);
    return (sel == CSR_WD_PC) ? pc_v : alu;
  endfunction

  function automatic void merge_store(input logic [`XLEN-1:0] addr,
      input logic [`XLEN-1:0] data, input logic [3:0] strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) ref_mem[addr[AW+1:2]][8*b +: 8] = data[8*b +: 8];
    end
  endfunction

  // Issue one op, update the model, wait for its commit
  task automatic run_op(input string name, input logic rd_en, input logic wr_en,
      input logic sgn, input logic [7:0] strb, input logic [`XLEN-1:0] mask,
      input logic [`XLEN-1:0] alu, input logic [`XLEN-1:0] src2_v,
      input logic [`XLEN-1:0] store_data, input wd_sel_t sel, input csr_wd_sel_t csel,
      input logic [RW-1:0] rd_v, input logic [CW-1:0] csr_v, input logic reg_we,
      input logic csr_we, input logic ecall_v);
    logic [`XLEN-1:0] exp_wd;
    logic [`XLEN-1:0] pc_v;
    logic [`XLEN-1:0] instr_v;
    pc_v = issue_pc;
    issue_pc = issue_pc + 4;
    instr_v = $urandom;
    exp_wd = predict_wd(sel, alu, pc_v, src2_v, mask, sgn);
    if (wr_en) merge_store(alu, store_data, strb[3:0]);
    if (reg_we && rd_v != 0) ref_regs[rd_v] = exp_wd;
    if (csr_we) ref_csrs[csr_v] = predict_csr(csel, alu, pc_v);
    name_q.push_back(name);
    exp_wd_q.push_back(exp_wd);
    exp_pc_q.push_back(pc_v);
    exp_pc_next_q.push_back(pc_v + 4);
    exp_instr_q.push_back(instr_v);
    exp_rd_q.push_back(rd_v);
    exp_ecall_q.push_back(ecall_v);
    @(posedge clk);
    ren <= rd_en;
    wen <= wr_en;
    mem_signed <= sgn;
    wmask <= strb;
    rmask <= mask;
    exu_result <= alu;
    pc <= pc_v;
    pc_next <= pc_v + 4;
    instruction <= instr_v;
    src2 <= src2_v;
    rsb <= store_data;
    wd_sel <= sel;
    csr_wd_sel <= csel;
    rd <= rd_v;
    csr_rd <= csr_v;
    reg_write_en <= reg_we;
    csreg_write_en <= csr_we;
    ecall <= ecall_v;
    lsu_receive_valid <= 1'b1;
    do @(posedge clk); while (!lsu_send_ready);
    lsu_receive_valid <= 1'b0;
    do @(posedge clk); while (!commit_valid);
  endtask

  task automatic store_op(input string name, input logic [`XLEN-1:0] addr,
      input logic [`XLEN-1:0] data, input logic [3:0] strb);
    run_op(name, 1'b0, 1'b1, 1'b0, {4'h0, strb}, '0, addr, $urandom, data,
           WD_ALU, CSR_WD_ALU, '0, '0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic load_op(input string name, input logic [`XLEN-1:0] addr,
      input logic [`XLEN-1:0] mask, input logic sgn, input logic [RW-1:0] rd_v);
    run_op(name, 1'b1, 1'b0, sgn, 8'h0, mask, addr, $urandom, $urandom,
           WD_LOAD, CSR_WD_ALU, rd_v, '0, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic read_back_reg(input string name, input logic [RW-1:0] idx);
    @(posedge clk);
    rs1_addr <= idx;
    rs2_addr <= idx;
    @(posedge clk);
    check_data({name, " rs1"}, ref_regs[idx], rs1_data);
    check_data({name, " rs2"}, ref_regs[idx], rs2_data);
  endtask

  task automatic read_back_csr(input string name, input logic [CW-1:0] idx);
    @(posedge clk);
    csr_raddr <= idx;
    @(posedge clk);
    check_data(name, ref_csrs[idx], csr_rdata);
  endtask

  // Commit checker and LSU handshake monitor
  always @(posedge clk) begin
    if (rst) begin
      ready_pulses = 0;
      busy_rises = 0;
      busy_q = 1'b0;
      fell_q = 1'b0;
    end else begin
      if (lsu_state && !busy_q) busy_rises++;
      if (lsu_send_ready) begin
        ready_pulses++;
        if (!busy_q) begin
          $display("ERROR: lsu_state was low in the cycle the op was accepted");
          protocol_errors++;
        end
      end
      if (commit_valid) begin
        if (ready_pulses != 1 || busy_rises != 1 || lsu_state || !fell_q) begin
          $display("ERROR: bad handshake before commit at pc %h (%0d ready pulses, %0d busy)",
                   commit_pc, ready_pulses, busy_rises);
          protocol_errors++;
        end
        ready_pulses = 0;
        busy_rises = 0;
        if (exp_wd_q.size() == 0) begin
          $display("ERROR: commit_valid seen with no op outstanding");
          protocol_errors++;
        end else begin
          tname = name_q.pop_front();
          check_data({tname, " wd"}, exp_wd_q.pop_front(), commit_wd);
          check_data({tname, " pc"}, exp_pc_q.pop_front(), commit_pc);
          check_data({tname, " pc_next"}, exp_pc_next_q.pop_front(), commit_pc_next);
          check_data({tname, " instr"}, exp_instr_q.pop_front(), commit_instr);
          check_reg_index({tname, " rd"}, exp_rd_q.pop_front(), commit_rd);
          check_flag({tname, " ecall"}, exp_ecall_q.pop_front(), commit_ecall);
          commit_count++;
        end
      end
      fell_q = busy_q && !lsu_state;
      busy_q = lsu_state;
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int kind;
    int width;
    int off;
    logic [3:0] strb;
    logic [`XLEN-1:0] word_addr;
    logic [`XLEN-1:0] mask;
    wd_sel_t sel;
    void'($urandom(32'h258d9832));
    {ren, wen, mem_signed, reg_write_en, csreg_write_en, ecall} = '0;
    lsu_receive_valid = 1'b0;
    wmask = '0;
    {rmask, exu_result, pc, pc_next, instruction, src2, rsb} = '0;
    wd_sel = WD_ALU;
    csr_wd_sel = CSR_WD_ALU;
    {rd, csr_rd, rs1_addr, rs2_addr, csr_raddr} = '0;
    value_errors = 0;
    protocol_errors = 0;
    commit_count = 0;
    issue_pc = 32'h0000_1000;
    for (int r = 0; r < `NUM_REGS; r++) ref_regs[r] = '0;
    for (int c = 0; c < `NUM_CSRS; c++) ref_csrs[c] = '0;
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Word store then load back
    store_op("sw_lw store", 32'h200, 32'hc3a5_1e69, 4'hf);
    load_op("sw_lw load", 32'h200, 32'hffff_ffff, 1'b0, 5'd5);
    read_back_reg("sw_lw x5", 5'd5);

    // Sub-word loads, every aligned offset
    store_op("ext store", 32'h204, 32'h80f3_7f91, 4'hf);
    for (int o = 0; o < 4; o++) begin
      for (int s = 0; s < 2; s++) begin
        load_op($sformatf("lb off%0d sgn%0d", o, s), 32'h204 + o, 32'hff, s[0], 5'd6);
        read_back_reg($sformatf("lb off%0d sgn%0d x6", o, s), 5'd6);
        if (o % 2 == 0) begin
          load_op($sformatf("lh off%0d sgn%0d", o, s), 32'h204 + o, 32'hffff, s[0], 5'd6);
          read_back_reg($sformatf("lh off%0d sgn%0d x6", o, s), 5'd6);
        end
      end
    end
    store_op("merge base", 32'h208, 32'h0, 4'hf);
    store_op("sb lane1", 32'h209, 32'h0000_a500, 4'b0010);
    store_op("sh upper", 32'h20a, 32'h8001_0000, 4'b1100);
    load_op("merge lw", 32'h208, 32'hffff_ffff, 1'b0, 5'd4);
    load_op("merge lh", 32'h20a, 32'hffff, 1'b1, 5'd3);

    // Plain ops, each select, with CSR writes
    run_op("alu", 0, 0, 0, 0, 0, 32'h1234_5678, $urandom, 0, WD_ALU, CSR_WD_ALU,
           5'd7, 2'd1, 1, 1, 0);
    run_op("link", 0, 0, 0, 0, 0, $urandom, $urandom, 0, WD_LINK, CSR_WD_PC,
           5'd8, 2'd2, 1, 1, 0);
    run_op("src2", 0, 0, 0, 0, 0, $urandom, 32'hfeed_0042, 0, WD_SRC2, CSR_WD_ALU,
           5'd9, 2'd0, 1, 0, 0);
    for (int r = 7; r < 10; r++) read_back_reg($sformatf("plain x%0d", r), r);
    read_back_csr("csr1 alu", 2'd1);
    read_back_csr("csr2 pc", 2'd2);

    // No-write cases and ecall forwarding
    run_op("rd0", 0, 0, 0, 0, 0, 32'hffff_ffff, 0, 0, WD_ALU, CSR_WD_ALU, 5'd0, 0, 1, 0, 0);
    read_back_reg("rd0 x0", 5'd0);
    run_op("we low", 0, 0, 0, 0, 0, 32'h5555_aaaa, 0, 0, WD_ALU, CSR_WD_ALU, 5'd7, 0, 0, 0, 0);
    read_back_reg("we low x7", 5'd7);
    run_op("ecall", 0, 0, 0, 0, 0, $urandom, 0, 0, WD_ALU, CSR_WD_ALU, 5'd10, 0, 1, 0, 1);

    // Random mix over a 16-word window
    for (int w = 0; w < 16; w++) begin
      store_op($sformatf("preload %0d", w), 32'h100 + 4 * w, $urandom, 4'hf);
    end
    for (int n = 0; n < 200; n++) begin
      kind = $urandom_range(0, 2);
      width = $urandom_range(0, 2);  // Byte, half, word
      word_addr = 32'h100 + 4 * $urandom_range(0, 15);
      off = (width == 0) ? $urandom_range(0, 3) : (width == 1) ? 2 * $urandom_range(0, 1) : 0;
      if (kind == 0) begin
        strb = (width == 0) ? (4'b0001 << off) : (width == 1) ? (4'b0011 << off) : 4'b1111;
        store_op($sformatf("rand%0d store", n), word_addr + off, $urandom, strb);
      end else if (kind == 1) begin
        mask = (width == 0) ? 32'hff : (width == 1) ? 32'hffff : 32'hffff_ffff;
        load_op($sformatf("rand%0d load", n), word_addr + off, mask,
                (width < 2) ? 1'($urandom_range(0, 1)) : 1'b0, $urandom_range(0, 31));
      end else begin
        case ($urandom_range(0, 2))
          0: sel = WD_ALU;
          1: sel = WD_LINK;
          default: sel = WD_SRC2;
        endcase
        run_op($sformatf("rand%0d plain", n), 0, 0, 0, 0, 0, $urandom, $urandom, 0, sel,
               csr_wd_sel_t'($urandom_range(0, 1)), $urandom_range(0, 31),
               $urandom_range(0, 3), $urandom_range(0, 7) != 0, $urandom_range(0, 1),
               $urandom_range(0, 7) == 0);
      end
    end
    for (int r = 0; r < `NUM_REGS; r++) read_back_reg($sformatf("final x%0d", r), r);
    for (int c = 0; c < `NUM_CSRS; c++) read_back_csr($sformatf("final csr%0d", c), c);

    if (exp_wd_q.size() != 0) begin
      $display("ERROR: %0d ops never committed", exp_wd_q.size());
      protocol_errors++;
    end
    $display("Errors: %0d value, %0d protocol, after %0d commits",
             value_errors, protocol_errors, commit_count);
    if (value_errors + protocol_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
